// File: logic/cache_geom_pkg.sv
package cache_geom_pkg;

        // Data and address word
        typedef logic [31:0] word_t;

        localparam int DEF_SETS = 8;
        localparam int IDX_W = 3;
        localparam int TAG_W = 26;

        // Byte address as seen by the cache
        typedef struct packed {
                logic [TAG_W-1:0] tag;
                logic [IDX_W-1:0] idx;
                logic wsel;
                logic [1:0] boff;
        } line_addr_t;

        // One way of one set, 92 bits
        typedef struct packed {
                logic valid;
                logic dirty;
                logic [TAG_W-1:0] tag;
                word_t [1:0] data;
        } frame_t;

endpackage

// File: logic/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

        typedef enum logic [3:0] {
                LOOKUP,
                WB1,
                WB2,
                FILL1,
                FILL2,
                FLUSH_SCAN,
                FLUSH_WB1,
                FLUSH_WB2,
                DONE
        } ctrl_state_t;

        // Byte distance from word 0 to word 1 of a line
        localparam int WORD_STEP = 4;

endpackage

// File: logic/line_store_if.sv
`timescale 1ns/1ns

interface line_store_if;
        import cache_geom_pkg::*;

        logic [IDX_W-1:0] idx;
        logic [TAG_W-1:0] req_tag;

        // Word index, data and way for updates
        logic wr_word;
        word_t wr_data;
        logic wr_way;
        // Way whose frame is read out
        logic wr_sel;

        logic wr_en;
        logic set_tag;
        logic mark_valid;
        logic mark_dirty;
        logic clear_line;
        logic touch;

        logic hit;
        logic hit_way;
        logic victim_way;
        logic victim_dirty;
        logic [TAG_W-1:0] victim_tag;
        word_t rd_word0;
        word_t rd_word1;

        modport ctrl (
                output idx, req_tag, wr_word, wr_data, wr_way, wr_sel,
                output wr_en, set_tag, mark_valid, mark_dirty, clear_line, touch,
                input hit, hit_way, victim_way, victim_dirty, victim_tag,
                input rd_word0, rd_word1
        );

        modport store (
                input idx, req_tag, wr_word, wr_data, wr_way, wr_sel,
                input wr_en, set_tag, mark_valid, mark_dirty, clear_line, touch,
                output hit, hit_way, victim_way, victim_dirty, victim_tag,
                output rd_word0, rd_word1
        );

endinterface

// File: logic/line_store.sv
`timescale 1ns/1ns

module line_store #(
        parameter int SETS = cache_geom_pkg::DEF_SETS
) (
        input logic CLK,
        input logic nRST,
        line_store_if.store ls
);
        import cache_geom_pkg::*;

        frame_t lines [SETS][2];
        // Most recently used way per set
        logic [SETS-1:0] mru;
        logic [1:0] match;
        frame_t sel_frame;

        // Tag compare on both ways of the set
        always_comb begin
                for (int w = 0; w < 2; w++) begin
                        match[w] = lines[ls.idx][w].valid &&
                                   (lines[ls.idx][w].tag == ls.req_tag);
                end
        end

        assign ls.hit = |match;
        assign ls.hit_way = match[1];

        // Replace the way that was not used last
        assign ls.victim_way = ~mru[ls.idx];

        assign sel_frame = lines[ls.idx][ls.wr_sel];
        assign ls.victim_dirty = sel_frame.valid && sel_frame.dirty;
        assign ls.victim_tag = sel_frame.tag;
        assign ls.rd_word0 = sel_frame.data[0];
        assign ls.rd_word1 = sel_frame.data[1];

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        mru <= '0;
                        for (int s = 0; s < SETS; s++) begin
                                for (int w = 0; w < 2; w++) begin
                                        lines[s][w].valid <= 1'b0;
                                        lines[s][w].dirty <= 1'b0;
                                end
                        end
                end else begin
                        // New tag starts out invalid and clean
                        if (ls.set_tag) begin
                                lines[ls.idx][ls.wr_way].tag <= ls.req_tag;
                                lines[ls.idx][ls.wr_way].valid <= 1'b0;
                                lines[ls.idx][ls.wr_way].dirty <= 1'b0;
                        end
                        if (ls.clear_line) begin
                                lines[ls.idx][ls.wr_way].valid <= 1'b0;
                                lines[ls.idx][ls.wr_way].dirty <= 1'b0;
                        end
                        if (ls.mark_valid) begin
                                lines[ls.idx][ls.wr_way].valid <= 1'b1;
                        end
                        if (ls.mark_dirty) begin
                                lines[ls.idx][ls.wr_way].dirty <= 1'b1;
                        end
                        if (ls.wr_en) begin
                                lines[ls.idx][ls.wr_way].data[ls.wr_word] <= ls.wr_data;
                        end
                        if (ls.touch) begin
                                mru[ls.idx] <= ls.wr_way;
                        end
                end
        end

endmodule

// File: logic/dcache_ctrl.sv
`timescale 1ns/1ns

module dcache_ctrl #(
        parameter int SETS = cache_geom_pkg::DEF_SETS
) (
        input logic CLK,
        input logic nRST,
        input logic halt,
        input logic dmem_ren,
        input logic dmem_wen,
        input cache_geom_pkg::word_t dmem_addr,
        input cache_geom_pkg::word_t dmem_store,
        output cache_geom_pkg::word_t dmem_load,
        output logic dhit,
        output logic flushed,
        output logic mem_ren,
        output logic mem_wen,
        output cache_geom_pkg::word_t mem_addr,
        output cache_geom_pkg::word_t mem_store,
        input cache_geom_pkg::word_t mem_load,
        input logic mem_wait,
        line_store_if.ctrl ls
);
        import cache_geom_pkg::*;
        import cache_ctrl_pkg::*;

        ctrl_state_t state;
        ctrl_state_t next_state;
        line_addr_t req;

        // Way being filled or written back on a miss
        logic way_q;
        logic next_way;

        // Flush position
        logic [IDX_W-1:0] scan_set;
        logic [IDX_W-1:0] next_scan_set;
        logic scan_way;
        logic next_scan_way;
        logic scan_last;
        logic flushing;

        // Memory address parts
        logic [TAG_W-1:0] line_tag;
        logic line_word;
        word_t line_base;

        assign req = line_addr_t'(dmem_addr);
        assign flushing = (state == FLUSH_SCAN) || (state == FLUSH_WB1) ||
                          (state == FLUSH_WB2);
        assign scan_last = (scan_set == IDX_W'(SETS - 1)) && scan_way;

        assign line_base = {line_tag, ls.idx, 3'b000};
        assign mem_addr = line_word ? line_base + word_t'(WORD_STEP) : line_base;

        assign flushed = (state == DONE);

        always_comb begin
                next_state = state;
                next_way = way_q;
                next_scan_set = scan_set;
                next_scan_way = scan_way;

                dhit = 1'b0;
                dmem_load = '0;
                mem_ren = 1'b0;
                mem_wen = 1'b0;
                mem_store = '0;
                line_tag = req.tag;
                line_word = 1'b0;

                ls.idx = req.idx;
                ls.req_tag = req.tag;
                ls.wr_word = req.wsel;
                ls.wr_data = dmem_store;
                ls.wr_way = way_q;
                ls.wr_sel = way_q;
                ls.wr_en = 1'b0;
                ls.set_tag = 1'b0;
                ls.mark_valid = 1'b0;
                ls.mark_dirty = 1'b0;
                ls.clear_line = 1'b0;
                ls.touch = 1'b0;

                // Flush walks the sets by its own counter
                if (flushing) begin
                        ls.idx = scan_set;
                        ls.wr_way = scan_way;
                        ls.wr_sel = scan_way;
                end

                case (state)
                LOOKUP: begin
                        ls.wr_way = ls.hit_way;
                        ls.wr_sel = ls.hit ? ls.hit_way : ls.victim_way;
                        if (halt) begin
                                next_state = FLUSH_SCAN;
                                next_scan_set = '0;
                                next_scan_way = 1'b0;
                        end else if (dmem_ren || dmem_wen) begin
                                if (ls.hit) begin
                                        dhit = 1'b1;
                                        ls.touch = 1'b1;
                                        dmem_load = req.wsel ? ls.rd_word1 : ls.rd_word0;
                                        if (dmem_wen) begin
                                                ls.wr_en = 1'b1;
                                                ls.mark_dirty = 1'b1;
                                        end
                                end else begin
                                        next_way = ls.victim_way;
                                        next_state = ls.victim_dirty ? WB1 : FILL1;
                                end
                        end
                end
                WB1, FLUSH_WB1: begin
                        mem_wen = 1'b1;
                        line_tag = ls.victim_tag;
                        mem_store = ls.rd_word0;
                        if (!mem_wait) begin
                                next_state = (state == WB1) ? WB2 : FLUSH_WB2;
                        end
                end
                WB2: begin
                        mem_wen = 1'b1;
                        line_tag = ls.victim_tag;
                        line_word = 1'b1;
                        mem_store = ls.rd_word1;
                        if (!mem_wait) begin
                                ls.clear_line = 1'b1;
                                next_state = FILL1;
                        end
                end
                FILL1: begin
                        mem_ren = 1'b1;
                        if (!mem_wait) begin
                                ls.set_tag = 1'b1;
                                ls.wr_en = 1'b1;
                                ls.wr_word = 1'b0;
                                ls.wr_data = mem_load;
                                next_state = FILL2;
                        end
                end
                FILL2: begin
                        mem_ren = 1'b1;
                        line_word = 1'b1;
                        if (!mem_wait) begin
                                ls.wr_en = 1'b1;
                                ls.wr_word = 1'b1;
                                ls.wr_data = mem_load;
                                ls.mark_valid = 1'b1;
                                // Request hits on the way back through LOOKUP
                                next_state = LOOKUP;
                        end
                end
                FLUSH_SCAN: begin
                        if (ls.victim_dirty) begin
                                next_state = FLUSH_WB1;
                        end else if (scan_last) begin
                                next_state = DONE;
                        end else begin
                                {next_scan_set, next_scan_way} =
                                        {scan_set, scan_way} + (IDX_W + 1)'(1);
                        end
                end
                FLUSH_WB2: begin
                        mem_wen = 1'b1;
                        line_tag = ls.victim_tag;
                        line_word = 1'b1;
                        mem_store = ls.rd_word1;
                        if (!mem_wait) begin
                                ls.clear_line = 1'b1;
                                if (scan_last) begin
                                        next_state = DONE;
                                end else begin
                                        next_state = FLUSH_SCAN;
                                        {next_scan_set, next_scan_way} =
                                                {scan_set, scan_way} + (IDX_W + 1)'(1);
                                end
                        end
                end
                // Held until reset
                DONE: begin
                        next_state = DONE;
                end
                default: begin
                        next_state = LOOKUP;
                end
                endcase
        end

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        state <= LOOKUP;
                        way_q <= 1'b0;
                        scan_set <= '0;
                        scan_way <= 1'b0;
                end else begin
                        state <= next_state;
                        way_q <= next_way;
                        scan_set <= next_scan_set;
                        scan_way <= next_scan_way;
                end
        end

endmodule

// File: logic/dcache.sv
`timescale 1ns/1ns

module dcache #(
        parameter int SETS = cache_geom_pkg::DEF_SETS
) (
        input logic CLK,
        input logic nRST,

        // Processor side
        input logic halt,
        input logic dmem_ren,
        input logic dmem_wen,
        input cache_geom_pkg::word_t dmem_addr,
        input cache_geom_pkg::word_t dmem_store,
        output cache_geom_pkg::word_t dmem_load,
        output logic dhit,
        output logic flushed,

        // Memory side
        output logic mem_ren,
        output logic mem_wen,
        output cache_geom_pkg::word_t mem_addr,
        output cache_geom_pkg::word_t mem_store,
        input cache_geom_pkg::word_t mem_load,
        input logic mem_wait
);

        line_store_if ls_if ();

        line_store #(
                .SETS(SETS)
        ) line_store_i (
                .CLK(CLK),
                .nRST(nRST),
                .ls(ls_if.store)
        );

        dcache_ctrl #(
                .SETS(SETS)
        ) dcache_ctrl_i (
                .CLK(CLK),
                .nRST(nRST),
                .halt(halt),
                .dmem_ren(dmem_ren),
                .dmem_wen(dmem_wen),
                .dmem_addr(dmem_addr),
                .dmem_store(dmem_store),
                .dmem_load(dmem_load),
                .dhit(dhit),
                .flushed(flushed),
                .mem_ren(mem_ren),
                .mem_wen(mem_wen),
                .mem_addr(mem_addr),
                .mem_store(mem_store),
                .mem_load(mem_load),
                .mem_wait(mem_wait),
                .ls(ls_if.ctrl)
        );

endmodule

// File: dv/dcache_checker.sv
`timescale 1ns/1ns

module dcache_checker (
        input logic CLK,
        input logic nRST,
        input logic mem_ren,
        input logic mem_wen,
        input logic mem_wait,
        input cache_geom_pkg::word_t mem_addr,
        input cache_geom_pkg::word_t mem_store,
        input logic dhit,
        input logic flushed
);

        a_one_dir: assert property (@(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen))
                else $error("mem_ren and mem_wen high together");

        // Word in progress held while memory stalls
        a_hold: assert property (@(posedge CLK) disable iff (!nRST)
                (mem_ren || mem_wen) && mem_wait |=>
                $stable(mem_ren) && $stable(mem_wen) && $stable(mem_addr) && $stable(mem_store))
                else $error("memory request changed while mem_wait was high");

        a_hit_flush: assert property (@(posedge CLK) disable iff (!nRST) !(dhit && flushed))
                else $error("dhit and flushed high together");

        a_flush_sticky: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
                else $error("flushed dropped before reset");

endmodule

bind dcache_ctrl dcache_checker checker_i (
        .CLK(CLK),
        .nRST(nRST),
        .mem_ren(mem_ren),
        .mem_wen(mem_wen),
        .mem_wait(mem_wait),
        .mem_addr(mem_addr),
        .mem_store(mem_store),
        .dhit(dhit),
        .flushed(flushed)
);

// File: dv/dcache_tb.sv
`timescale 1ns/1ns

module dcache_tb;
        import cache_geom_pkg::*;

        localparam word_t PATTERN = 32'hA5A50000;
        localparam int RANDOM_OPS = 200;
        // Reset load, store and load, random mix, conflict stores and reload
        localparam int OPS = 1 + 2 + RANDOM_OPS + 4;
        localparam int LIMIT = OPS * (5 + 4 * 4) + 16 * 2 * 4;

        logic CLK = 1'b0;
        logic nRST;
        logic halt;
        logic dmem_ren;
        logic dmem_wen;
        word_t dmem_addr;
        word_t dmem_store;
        word_t dmem_load;
        logic dhit;
        logic flushed;
        logic mem_ren;
        logic mem_wen;
        word_t mem_addr;
        word_t mem_store;
        word_t mem_load = '0;
        logic mem_wait = 1'b0;

        word_t lfsr = 32'h1d44;
        word_t ref_mem [64];
        word_t mem_arr [64];
        logic [1:0] wait_tab [256];
        logic [7:0] wait_ptr = '0;
        logic [1:0] wait_left = '0;
        logic busy = 1'b0;
        int cycles = 0;
        int errors = 0;
        int checks = 0;
        int tests = 0;
        int failed_tests = 0;
        int err_mark = 0;

        dcache #(.SETS(DEF_SETS)) dcache_i (.*);

        always #50 CLK = ~CLK;

        function automatic word_t lfsr_next(input word_t s);
                // Taps 32, 22, 2, 1
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        function automatic word_t rand_bits(input int n);
                word_t r;
                r = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr = lfsr_next(lfsr);
                        r = {r[30:0], lfsr[0]};
                end
                return r;
        endfunction

        task automatic compare_word(input string test, input word_t expected, input word_t actual);
                checks++;
                if (expected !== actual) begin
                        errors++;
                        $display("FAILED %s expected %h actual %h", test, expected, actual);
                end
        endtask

        task automatic finish_test(input string test);
                tests++;
                if (errors == err_mark) begin
                        $display("PASS %s", test);
                end else begin
                        failed_tests++;
                        $display("FAIL %s", test);
                end
                err_mark = errors;
        endtask

        // One processor request, held until dhit
        task automatic access(input logic wr, input logic [5:0] word, input word_t data,
                              output word_t load);
                @(negedge CLK);
                dmem_ren = ~wr;
                dmem_wen = wr;
                dmem_addr = {24'h0, word, 2'b00};
                dmem_store = data;
                @(posedge CLK);
                while (!dhit) @(posedge CLK);
                load = dmem_load;
                if (wr) ref_mem[word] = data;
                @(negedge CLK);
                dmem_ren = 1'b0;
                dmem_wen = 1'b0;
        endtask

        // Memory with 0 to 3 wait cycles per word
        always @(negedge CLK) begin
                if (!nRST) begin
                        for (int i = 0; i < 64; i++) mem_arr[i[5:0]] = word_t'(i) ^ PATTERN;
                        busy = 1'b0;
                        mem_wait = 1'b0;
                end else if (mem_ren || mem_wen) begin
                        if (!busy) begin
                                busy = 1'b1;
                                wait_left = wait_tab[wait_ptr];
                                wait_ptr = wait_ptr + 8'd1;
                        end
                        if (wait_left == 2'd0) begin
                                mem_wait = 1'b0;
                                busy = 1'b0;
                                if (mem_wen) mem_arr[mem_addr[7:2]] = mem_store;
                                else mem_load = mem_arr[mem_addr[7:2]];
                        end else begin
                                mem_wait = 1'b1;
                                wait_left = wait_left - 2'd1;
                        end
                end else begin
                        mem_wait = 1'b0;
                        busy = 1'b0;
                end
        end

        always @(posedge CLK) begin
                cycles++;
                if (cycles > LIMIT) begin
                        $display("timeout: cache did not answer within %0d cycles", LIMIT);
                        $display("TESTBENCH FAILED");
                        $finish;
                end
        end

        initial begin
                logic [5:0] word;
                logic [5:0] a_word;
                logic [1:0] tag0;
                logic [2:0] set;
                logic wr;
                word_t data;
                word_t a_data;
                word_t load;

                nRST = 1'b0;
                halt = 1'b0;
                dmem_ren = 1'b0;
                dmem_wen = 1'b0;
                dmem_addr = '0;
                dmem_store = '0;
                for (int i = 0; i < 64; i++) ref_mem[i[5:0]] = word_t'(i) ^ PATTERN;
                for (int i = 0; i < 256; i++) wait_tab[i[7:0]] = 2'(rand_bits(2));
                repeat (2) @(negedge CLK);
                nRST = 1'b1;

                @(negedge CLK);
                compare_word("reset_state", '0, {28'h0, dhit, flushed, mem_ren, mem_wen});
                word = 6'(rand_bits(6));
                access(1'b0, word, '0, load);
                compare_word("reset_state", word_t'(word) ^ PATTERN, load);
                finish_test("reset_state");

                word = 6'(rand_bits(6));
                data = rand_bits(32);
                access(1'b1, word, data, load);
                access(1'b0, word, '0, load);
                compare_word("store_load", data, load);
                finish_test("store_load");

                for (int n = 0; n < RANDOM_OPS; n++) begin
                        wr = 1'(rand_bits(1));
                        word = 6'(rand_bits(6));
                        data = rand_bits(32);
                        if (!wr) data = ref_mem[word];
                        access(wr, word, data, load);
                        if (!wr) compare_word("random_mix", data, load);
                end
                finish_test("random_mix");

                // Three tags in one set, the first one gets evicted dirty
                tag0 = 2'(rand_bits(2));
                set = 3'(rand_bits(3));
                a_word = {tag0, set, 1'b0};
                a_data = rand_bits(32);
                access(1'b1, a_word, a_data, load);
                access(1'b1, {tag0 + 2'd1, set, 1'b0}, rand_bits(32), load);
                access(1'b1, {tag0 + 2'd2, set, 1'b0}, rand_bits(32), load);
                compare_word("conflict_evict", a_data, mem_arr[a_word]);
                access(1'b0, a_word, '0, load);
                compare_word("conflict_evict", a_data, load);
                finish_test("conflict_evict");

                @(negedge CLK);
                halt = 1'b1;
                @(posedge CLK);
                while (!flushed) @(posedge CLK);
                for (int i = 0; i < 64; i++) begin
                        compare_word("halt_flush", ref_mem[i[5:0]], mem_arr[i[5:0]]);
                end
                finish_test("halt_flush");

                $display("tests %0d, failed tests %0d, checks %0d, mismatches %0d",
                         tests, failed_tests, checks, errors);
                if (errors == 0) begin
                        $display("TESTBENCH PASSED");
                end else begin
                        $display("TESTBENCH FAILED");
                end
                $finish;
        end

endmodule

// File: src.f
logic/cache_geom_pkg.sv
logic/cache_ctrl_pkg.sv
logic/line_store_if.sv
logic/line_store.sv
logic/dcache_ctrl.sv
logic/dcache.sv
dv/dcache_checker.sv
dv/dcache_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module dcache_tb -o dcache_sim
./obj_dir/dcache_sim | tee sim.log

if grep -q '^TESTBENCH PASSED$' sim.log; then
        echo "simulation passed"
        exit 0
else
        echo "simulation failed"
        exit 1
fi
